/* dv/exu_model.svh */
// Reference model of per-thread icc, window pointer and result with a one-cycle write delay
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// State as the thread registers hold it
logic [icc_w-1:0]      m_icc [num_thr];
logic [cwp_w-1:0]      m_cwp [num_thr];
logic [num_thr-1:0]    m_mask;

// Entry in the write stage, shown on the outputs this cycle
logic                  p_vld;
logic [thr_w_bits-1:0] p_thr;
logic [data_w-1:0]     p_result;
logic [icc_w-1:0]      p_icc;
logic [cwp_w-1:0]      p_cwp;
logic                  p_icc_wen;
logic                  p_cwp_wen;

function automatic void model_reset();
   for (int i = 0; i < num_thr; i++) begin
      m_icc[i] = '0;
      m_cwp[i] = '0;
   end
   m_mask     = '1;
   p_vld      = 1'b0;
   p_icc_wen  = 1'b0;
   p_cwp_wen  = 1'b0;
endfunction

// One clock cycle: execute the new issue, retire the write stage, then the mask write
function automatic void model_step(input logic vld, input logic [thr_w_bits-1:0] thr,
      input instr_word_u w, input logic [data_w-1:0] a, input logic [data_w-1:0] b,
      input logic wen, input logic [num_thr-1:0] wdata);
   logic [icc_w-1:0]  icc_old;
   logic [cwp_w-1:0]  cwp_new;
   logic [data_w-1:0] res;
   logic [63:0]       ures;
   longint            sres;
   logic              cin;
   logic              v;
   logic              c;
   logic              is_alu;
   logic              is_win;
   // Execute sees registered state only, no bypass from the write stage
   icc_old = m_icc[thr];
   cwp_new = m_cwp[thr];
   cin     = (w.arith.op == op_addx) ? icc_old[icc_c] : 1'b0;
   res     = '0;
   v       = 1'b0;
   c       = 1'b0;
   is_alu  = (w.arith.op <= op_xor);
   is_win  = 1'b0;
   case (w.arith.op)
      op_add, op_addx: begin
         ures = 64'(a) + 64'(b) + 64'(cin);
         sres = longint'(signed'(a)) + longint'(signed'(b)) + longint'(cin);
         res  = ures[data_w-1:0];
         c    = ures[data_w];
         // Overflow when the true signed sum does not fit the word
         v    = (sres != longint'(signed'(res)));
      end
      op_sub: begin
         sres = longint'(signed'(a)) - longint'(signed'(b));
         res  = a - b;
         // Carry is the unsigned borrow
         c    = (a < b);
         v    = (sres != longint'(signed'(res)));
      end
      op_and: res = a & b;
      op_or:  res = a | b;
      op_xor: res = a ^ b;
      op_save, op_restore: begin
         is_win  = 1'b1;
         res     = a + b;
         cwp_new = (w.win.op == op_save) ? cwp_new + 3'd1 : cwp_new - 3'd1;
      end
      default: res = '0;
   endcase

   // Last entry lands in the registers at the end of this cycle
   if (p_vld && p_icc_wen) m_icc[p_thr] = p_icc;
   if (p_vld && p_cwp_wen) m_cwp[p_thr] = p_cwp;

   // New write-stage entry; unwritten state still shows on the outputs
   p_vld     = vld && m_mask[thr];
   p_thr     = thr;
   p_result  = res;
   p_icc_wen = is_alu && w.arith.set_cc;
   p_cwp_wen = is_win;
   p_icc     = p_icc_wen ? {res[data_w-1], res == '0, v, c} : icc_old;
   p_cwp     = cwp_new;

   // Mask write counts from the next cycle on
   if (wen) m_mask = wdata;
endfunction

`endif

/* dv/tb_exu_top.sv */
// Testbench for the execute unit slice: random issue checked against a per-thread model
`timescale 1ns/1ps

module tb_exu_top
   import exu_pkg::*;
   ();

   localparam int clk_period   = 8;
   localparam int reset_cycles = 16;
   localparam int n_arith      = 200;
   localparam int n_icc        = 200;
   localparam int n_win        = 200;
   localparam int n_hazard     = 300;
   localparam int n_mask       = 200;
   // Directed steps and flushes across all tests, with slack
   localparam int n_directed   = 200;
   localparam int total_cycles = reset_cycles + n_arith + n_icc + n_win + n_hazard +
                                 n_mask + n_directed;
   localparam int timeout_ns   = total_cycles * clk_period + 500;

   logic                  clk;
   logic                  rst_n;
   logic                  issue_vld;
   logic [thr_w_bits-1:0] issue_thr;
   logic [instr_w-1:0]    instr;
   logic [data_w-1:0]     rs1;
   logic [data_w-1:0]     rs2;
   logic                  cfg_wen;
   logic [num_thr-1:0]    cfg_wdata;
   logic [num_thr-1:0]    cfg_rdata;
   logic [data_w-1:0]     result;
   logic                  result_vld;
   logic [icc_w-1:0]      icc_out;
   logic [cwp_w-1:0]      cwp_out;

   integer seed;
   int     err_count;
   int     check_count;
   int     test_count;
   int     errs_start;

   `include "exu_model.svh"

   exu_top u_exu_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue_vld  (issue_vld),
      .issue_thr  (issue_thr),
      .instr      (instr),
      .rs1        (rs1),
      .rs2        (rs2),
      .cfg_wen    (cfg_wen),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .result     (result),
      .result_vld (result_vld),
      .icc_out    (icc_out),
      .cwp_out    (cwp_out)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////
   task automatic check_value(input string what, input logic [data_w-1:0] got,
         input logic [data_w-1:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Edge values now and then so carry, overflow and zero come up
   function automatic logic [data_w-1:0] rand_operand();
      case ($unsigned($random(seed)) % 8)
         0: return '0;
         1: return '1;
         2: return 32'h8000_0000;
         3: return 32'h7fff_ffff;
         default: return $random(seed);
      endcase
   endfunction

   // Unused and reserved bits stay random
   function automatic instr_word_u make_instr(input logic [op_w-1:0] op, input logic set_cc);
      instr_word_u w;
      w = instr_word_u'($random(seed));
      if (op == op_save || op == op_restore) begin
         w.win.op = op;
      end else begin
         w.arith.op     = op;
         w.arith.set_cc = set_cc;
      end
      return w;
   endfunction

   // Check the write stage, then drive the next cycle 1 ns after the edge
   task automatic step(input logic vld, input logic [thr_w_bits-1:0] thr, input instr_word_u w,
         input logic [data_w-1:0] a, input logic [data_w-1:0] b,
         input logic wen, input logic [num_thr-1:0] wdata);
      @(posedge clk);
      #1;
      check_value("result_vld", result_vld, p_vld);
      if (p_vld) check_value("result", result, p_result);
      check_value("icc_out", icc_out, p_vld ? p_icc : '0);
      check_value("cwp_out", cwp_out, p_vld ? p_cwp : '0);
      check_value("cfg_rdata", cfg_rdata, m_mask);
      model_step(vld, thr, w, a, b, wen, wdata);
      issue_vld = vld;
      issue_thr = thr;
      instr     = w;
      rs1       = a;
      rs2       = b;
      cfg_wen   = wen;
      cfg_wdata = wdata;
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, '0, '0, '0, '0, 1'b0, '0);
   endtask

   task automatic issue_random(input int n, input logic [op_w-1:0] op_base, input int op_span,
         input int thr_span, input int vld_pct, input int cfg_pct);
      logic [op_w-1:0]       op;
      logic [thr_w_bits-1:0] thr;
      logic                  vld;
      logic                  wen;
      for (int i = 0; i < n; i++) begin
         op  = op_base + $unsigned($random(seed)) % op_span;
         thr = $unsigned($random(seed)) % thr_span;
         vld = ($unsigned($random(seed)) % 100) < vld_pct;
         wen = ($unsigned($random(seed)) % 100) < cfg_pct;
         step(vld, thr, make_instr(op, $random(seed)), rand_operand(), rand_operand(),
              wen, $random(seed));
      end
   endtask

   task automatic end_test(input string name);
      idle(2);
      test_count++;
      $display("test %-12s finished with %0d errors", name, err_count - errs_start);
      errs_start = err_count;
   endtask

   ////////////////////
   // Watchdog
   ////////////////////
   initial begin
      #(timeout_ns);
      $display("Run timed out after %0d ns, the tests did not finish", timeout_ns);
      $display(">>> FAIL");
      $finish;
   end

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin
      seed        = 32'h5d37_3d0c;
      err_count   = 0;
      check_count = 0;
      test_count  = 0;
      errs_start  = 0;
      rst_n       = 1'b0;
      issue_vld   = 1'b0;
      issue_thr   = '0;
      instr       = '0;
      rs1         = '0;
      rs2         = '0;
      cfg_wen     = 1'b0;
      cfg_wdata   = '0;
      model_reset();
      repeat (reset_cycles) @(posedge clk);
      #1 rst_n = 1'b1;

      // All threads enabled and zero state straight after reset
      check_value("mask after reset", cfg_rdata, {num_thr{1'b1}});
      for (int t = 0; t < num_thr; t++) begin
         step(1'b1, t, make_instr(op_or, 1'b0), '0, '0, 1'b0, '0);
         idle(1);
      end
      end_test("reset_state");

      issue_random(n_arith, op_add, 6, num_thr, 90, 0);
      end_test("arith");

      // Carry set on thread 2, then addx with and without set_cc
      step(1'b1, 2, make_instr(op_add, 1'b1), '1, 32'd1, 1'b0, '0);
      idle(1);
      step(1'b1, 2, make_instr(op_addx, 1'b0), 32'd5, 32'd6, 1'b0, '0);
      idle(1);
      step(1'b1, 2, make_instr(op_addx, 1'b1), '0, '0, 1'b0, '0);
      idle(1);
      issue_random(n_icc, op_add, 6, num_thr, 80, 0);
      end_test("icc");

      // Nine steps each way cross 7 to 0 and 0 to 7 on every thread
      for (int t = 0; t < num_thr; t++) begin
         for (int k = 0; k < 18; k++) begin
            step(1'b1, t, make_instr(k < 9 ? op_save : op_restore, 1'b0),
                 rand_operand(), rand_operand(), 1'b0, '0);
            idle(1);
         end
      end
      issue_random(n_win, op_add, 8, num_thr, 90, 0);
      end_test("window");

      // Clear the carry of thread 1 first
      step(1'b1, 1, make_instr(op_and, 1'b1), '0, '0, 1'b0, '0);
      idle(1);
      // Back-to-back on thread 1 so the first addx reads the old carry and the second the new
      step(1'b1, 1, make_instr(op_add, 1'b1), '1, '1, 1'b0, '0);
      step(1'b1, 1, make_instr(op_addx, 1'b0), '0, '0, 1'b0, '0);
      step(1'b1, 1, make_instr(op_addx, 1'b0), '0, '0, 1'b0, '0);
      // Two threads, always issuing, so same-thread neighbours are common
      issue_random(n_hazard, op_add, 8, 2, 100, 0);
      end_test("hazard");

      issue_random(n_mask, op_add, 8, num_thr, 90, 12);
      step(1'b0, '0, '0, '0, '0, 1'b1, '1);
      end_test("mask");

      $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* filelist.f */
source/exu_pkg.sv
source/exu_wb_if.sv
source/exu_thr_reg.sv
source/exu_alu.sv
source/exu_ctl_regs.sv
source/exu_top.sv
+incdir+dv
dv/tb_exu_top.sv

/* source/exu_alu.sv */
// Execute and write stage: decode, compute result, icc and window pointer, register into write
`timescale 1ns/1ps

module exu_alu
   import exu_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue_ok,
   input  logic [thr_w_bits-1:0] issue_thr,
   input  instr_word_u           instr,
   input  logic [data_w-1:0]     rs1,
   input  logic [data_w-1:0]     rs2,
   output logic [num_thr-1:0]    thr_e,
   input  logic [icc_w-1:0]      icc_e,
   input  logic [cwp_w-1:0]      cwp_e,
   exu_wb_if.wb                  wb,
   output logic [data_w-1:0]     result,
   output logic                  result_vld
);

   logic              is_arith;
   logic              is_win;
   logic [data_w:0]   sum_e;
   logic              v_e;
   logic              c_e;
   logic [icc_w-1:0]  icc_new;
   logic [cwp_w-1:0]  cwp_new;
   logic              icc_wen_e;

   // Thread index to one-hot, also drives the register read select
   always_comb begin
      thr_e = '0;
      thr_e[issue_thr] = 1'b1;
   end

   ////////////////////
   // Execute
   ////////////////////
   always_comb begin
      is_arith = 1'b0;
      is_win   = 1'b0;
      sum_e    = '0;
      v_e      = 1'b0;
      c_e      = 1'b0;
      cwp_new  = cwp_e;
      case (instr.arith.op)
         op_add, op_addx: begin
            is_arith = 1'b1;
            // Carry in only for addx
            sum_e = {1'b0, rs1} + {1'b0, rs2} +
                    {{data_w{1'b0}}, (instr.arith.op == op_addx) & icc_e[icc_c]};
            v_e = (rs1[data_w-1] == rs2[data_w-1]) && (sum_e[data_w-1] != rs1[data_w-1]);
            c_e = sum_e[data_w];
         end
         op_sub: begin
            is_arith = 1'b1;
            sum_e = {1'b0, rs1} - {1'b0, rs2};
            v_e = (rs1[data_w-1] != rs2[data_w-1]) && (sum_e[data_w-1] != rs1[data_w-1]);
            // Top bit is the borrow
            c_e = sum_e[data_w];
         end
         op_and: begin
            is_arith = 1'b1;
            sum_e = {1'b0, rs1 & rs2};
         end
         op_or: begin
            is_arith = 1'b1;
            sum_e = {1'b0, rs1 | rs2};
         end
         op_xor: begin
            is_arith = 1'b1;
            sum_e = {1'b0, rs1 ^ rs2};
         end
         default: begin
            // Window ops decode through their own view
            if (instr.win.op == op_save || instr.win.op == op_restore) begin
               is_win = 1'b1;
               sum_e = {1'b0, rs1} + {1'b0, rs2};
               // Save steps up, restore steps down, wraps mod eight
               cwp_new = (instr.win.op == op_save) ? cwp_e + 1'b1 : cwp_e - 1'b1;
            end
         end
      endcase
   end

   // New condition codes from the execute result
   always_comb begin
      icc_new        = '0;
      icc_new[icc_n] = sum_e[data_w-1];
      icc_new[icc_z] = (sum_e[data_w-1:0] == '0);
      icc_new[icc_v] = v_e;
      icc_new[icc_c] = c_e;
   end

   assign icc_wen_e = is_arith & instr.arith.set_cc;

   ////////////////////
   // Write stage
   ////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb.wen_w <= 1'b0;
      end else begin
         wb.wen_w <= issue_ok;
      end
   end

   // Payload, held when nothing issues
   always_ff @(posedge clk) begin
      if (issue_ok) begin
         result        <= sum_e[data_w-1:0];
         wb.thr_w      <= thr_e;
         wb.icc_wen    <= icc_wen_e;
         wb.cwp_wen    <= is_win;
         // Unchanged state passes through so outputs show the thread's value
         wb.icc_w_data <= icc_wen_e ? icc_new : icc_e;
         wb.cwp_w_data <= cwp_new;
      end
   end

   assign result_vld = wb.wen_w;

endmodule

/* source/exu_ctl_regs.sv */
// Control register block holding the thread-enable mask and gating issue
`timescale 1ns/1ps

module exu_ctl_regs
   import exu_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   // Configuration port
   input  logic                  cfg_wen,
   input  logic [num_thr-1:0]    cfg_wdata,
   output logic [num_thr-1:0]    cfg_rdata,
   // Issue check
   input  logic                  issue_vld,
   input  logic [thr_w_bits-1:0] issue_thr,
   output logic                  issue_ok
);

   // One enable bit per thread
   logic [num_thr-1:0] thr_en;
   // Enable bit of the issuing thread
   logic               thr_en_sel;

   ////////////////////
   // Mask register
   ////////////////////
   // All threads run out of reset
   // A write takes effect on the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         thr_en <= '1;
      end else if (cfg_wen) begin
         thr_en <= cfg_wdata;
      end
   end

   // Readback always shows the live mask
   assign cfg_rdata = thr_en;

   ////////////////////
   // Issue gate
   ////////////////////
   // Index the mask by the binary thread number
   assign thr_en_sel = thr_en[issue_thr];

   // Disabled thread: instruction dropped, no result and no state change
   // Pure combinational, checked in the execute cycle
   assign issue_ok = issue_vld & thr_en_sel;

endmodule

/* source/exu_pkg.sv */
// Execute unit package with thread count, widths, opcodes and instruction word format
package exu_pkg;

   ////////////////////
   // Thread geometry
   ////////////////////

   // Four hardware threads share one pipeline
   localparam int num_thr    = 4;
   // Width of a binary thread index
   localparam int thr_w_bits = 2;

   ////////////////////
   // Datapath widths
   ////////////////////

   // Operand and result width
   localparam int data_w  = 32;
   // Instruction word width
   localparam int instr_w = 32;
   // Condition codes n z v c
   localparam int icc_w   = 4;
   // Window pointer, eight windows
   localparam int cwp_w   = 3;

   // Bit positions inside icc
   localparam int icc_n = 3;
   localparam int icc_z = 2;
   localparam int icc_v = 1;
   localparam int icc_c = 0;

   ////////////////////
   // Opcodes
   ////////////////////

   // Opcode field width, top bits of the word
   localparam int op_w = 4;

   // Arithmetic and logic group
   localparam logic [op_w-1:0] op_add     = 4'h0;
   localparam logic [op_w-1:0] op_addx    = 4'h1;
   localparam logic [op_w-1:0] op_sub     = 4'h2;
   localparam logic [op_w-1:0] op_and     = 4'h3;
   localparam logic [op_w-1:0] op_or      = 4'h4;
   localparam logic [op_w-1:0] op_xor     = 4'h5;
   // Window group
   localparam logic [op_w-1:0] op_save    = 4'h6;
   localparam logic [op_w-1:0] op_restore = 4'h7;
   // Codes 8 to 15 are unassigned and write nothing back

   ////////////////////
   // Instruction word
   ////////////////////

   // One word, two decodes; op sits in the top bits of both views
   typedef union packed {
      // Arithmetic format
      struct packed {
         logic [op_w-1:0]         op;
         // Update icc when set
         logic                    set_cc;
         logic [instr_w-op_w-2:0] unused;
      } arith;
      // Window format
      struct packed {
         logic [op_w-1:0]         op;
         // No fields defined yet below op
         logic [instr_w-op_w-1:0] rsvd;
      } win;
   } instr_word_u;

endpackage

/* source/exu_thr_reg.sv */
// Per-thread state register with write-stage update and one-hot thread readout
`timescale 1ns/1ps

module exu_thr_reg
   import exu_pkg::*;
   #(parameter int size = cwp_w) (
   input  logic               clk,
   input  logic               rst_n,
   exu_wb_if.regs             wb,
   input  bit                 sel_cc,
   input  logic [num_thr-1:0] thr_out,
   output logic [size-1:0]    data_out
);

   logic [size-1:0] data_thr [num_thr];
   logic            wen_sel;
   logic [size-1:0] data_in_w;

   // Pick which half of the bus this copy follows
   assign wen_sel   = sel_cc ? wb.icc_wen : wb.cwp_wen;
   assign data_in_w = sel_cc ? size'(wb.icc_w_data) : size'(wb.cwp_w_data);

   ////////////////////
   // Storage
   ////////////////////
   always_ff @(posedge clk) begin
      for (int i = 0; i < num_thr; i++) begin
         if (!rst_n) begin
            data_thr[i] <= '0;
         end else if (wen_sel && wb.wen_w && wb.thr_w[i]) begin
            // Thread enable built here only
            data_thr[i] <= data_in_w;
         end
      end
   end

   ////////////////////
   // Output select
   ////////////////////
   // One-hot AND-OR mux, combinational read
   always_comb begin
      data_out = '0;
      for (int i = 0; i < num_thr; i++) begin
         data_out = data_out | ({size{thr_out[i]}} & data_thr[i]);
      end
   end

endmodule

/* source/exu_top.sv */
// Execute unit top: control registers, ALU and per-thread icc and window pointer copies
`timescale 1ns/1ps

module exu_top
   import exu_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   // Issue
   input  logic                  issue_vld,
   input  logic [thr_w_bits-1:0] issue_thr,
   input  logic [instr_w-1:0]    instr,
   input  logic [data_w-1:0]     rs1,
   input  logic [data_w-1:0]     rs2,
   // Configuration
   input  logic                  cfg_wen,
   input  logic [num_thr-1:0]    cfg_wdata,
   output logic [num_thr-1:0]    cfg_rdata,
   // Write-stage outputs
   output logic [data_w-1:0]     result,
   output logic                  result_vld,
   output logic [icc_w-1:0]      icc_out,
   output logic [cwp_w-1:0]      cwp_out
);

   logic               issue_ok;
   logic [num_thr-1:0] thr_e;
   logic [icc_w-1:0]   icc_e;
   logic [cwp_w-1:0]   cwp_e;

   // Write-stage update bus
   exu_wb_if wb_bus ();

   ////////////////////
   // Issue gating
   ////////////////////
   exu_ctl_regs u_ctl_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_wen   (cfg_wen),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .issue_vld (issue_vld),
      .issue_thr (issue_thr),
      .issue_ok  (issue_ok)
   );

   ////////////////////
   // Pipeline
   ////////////////////
   exu_alu u_alu (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue_ok   (issue_ok),
      .issue_thr  (issue_thr),
      .instr      (instr),
      .rs1        (rs1),
      .rs2        (rs2),
      .thr_e      (thr_e),
      .icc_e      (icc_e),
      .cwp_e      (cwp_e),
      .wb         (wb_bus.wb),
      .result     (result),
      .result_vld (result_vld)
   );

   ////////////////////
   // Thread state
   ////////////////////
   // Condition code copy
   exu_thr_reg #(.size(icc_w)) u_icc_reg (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb       (wb_bus.regs),
      .sel_cc   (1'b1),
      .thr_out  (thr_e),
      .data_out (icc_e)
   );

   // Window pointer copy
   exu_thr_reg #(.size(cwp_w)) u_cwp_reg (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb       (wb_bus.regs),
      .sel_cc   (1'b0),
      .thr_out  (thr_e),
      .data_out (cwp_e)
   );

   // Write-stage state, zero when write stage is empty
   assign icc_out = {icc_w{wb_bus.wen_w}} & wb_bus.icc_w_data;
   assign cwp_out = {cwp_w{wb_bus.wen_w}} & wb_bus.cwp_w_data;

endmodule

/* source/exu_wb_if.sv */
// Write-stage bus from the ALU to the per-thread state registers
`timescale 1ns/1ps

interface exu_wb_if
   import exu_pkg::*;
   ();

   // Write stage holds a valid instruction
   logic               wen_w;
   // One-hot thread of the write stage
   logic [num_thr-1:0] thr_w;
   // Which state copies this instruction updates
   logic               icc_wen;
   logic               cwp_wen;
   // New state values
   logic [icc_w-1:0]   icc_w_data;
   logic [cwp_w-1:0]   cwp_w_data;

   // Pipeline side drives the update
   modport wb (
      output wen_w, thr_w, icc_wen, cwp_wen, icc_w_data, cwp_w_data
   );

   // Register side consumes it
   modport regs (
      input wen_w, thr_w, icc_wen, cwp_wen, icc_w_data, cwp_w_data
   );

endinterface
